// ==== ecc_mem.f ====
+incdir+hdl
hdl/ecc_mem_pkg.sv
hdl/ecc_mem_if.sv
hdl/ecc_29_codec.sv
hdl/ecc_mem_array.sv
hdl/ecc_mem_ctrl.sv
hdl/ecc_mem_top.sv
tests/ecc_mem_tb.sv

// ==== tests/ecc_mem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ecc_mem_cfg.svh"

module ecc_mem_tb;

    localparam int CLK_PERIOD = 100;
    localparam int N_OPS      = 2 * `ECC_MEM_DEPTH + 2 * `ECC_DATA_W + 16 + 3 + 4 + 12;
    localparam int WATCHDOG   = (N_OPS * 6 + 40) * CLK_PERIOD;

    logic                     clk;
    logic                     arst_n;
    logic                     req_write;
    logic                     req_read;
    ecc_mem_pkg::ecc_addr_t   req_addr;
    ecc_mem_pkg::ecc_data_t   req_wdata;
    ecc_mem_pkg::ecc_data_t   inj_mask;
    logic                     scrub_en;
    logic                     bypass;
    logic                     ready;
    logic                     rsp_valid;
    ecc_mem_pkg::ecc_data_t   rsp_data;
    ecc_mem_pkg::ecc_status_e rsp_status;
    logic [7:0]               sbe_count;
    logic [7:0]               dbe_count;

    // reference model.
    ecc_mem_pkg::ecc_data_t   model_data [`ECC_MEM_DEPTH];
    ecc_mem_pkg::ecc_data_t   model_inj  [`ECC_MEM_DEPTH];
    logic [7:0]               exp_sbe;
    logic [7:0]               exp_dbe;
    logic [31:0]              rng;

    ecc_mem_top dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_write  (req_write),
        .req_read   (req_read),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .inj_mask   (inj_mask),
        .scrub_en   (scrub_en),
        .bypass     (bypass),
        .ready      (ready),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_status (rsp_status),
        .sbe_count  (sbe_count),
        .dbe_count  (dbe_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // checks
    // ------------------------------
    task automatic abort_run(input string why);
        $display("%0t ns: %s", $time, why);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input string what, input ecc_mem_pkg::ecc_data_t got,
                              input ecc_mem_pkg::ecc_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_status(input string what, input ecc_mem_pkg::ecc_status_e got,
                                input ecc_mem_pkg::ecc_status_e exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %s, expected %s", $time, what,
                     got.name(), exp.name());
            $display("TEST FAILED");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic check_count(input string what, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "count mismatch");
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "level mismatch");
        end
    endtask

    // ------------------------------
    // stimulus helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_data(output ecc_mem_pkg::ecc_data_t d);
        rng = xorshift32(rng);
        d   = rng[`ECC_DATA_W-1:0];
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready) begin
            if (n == 8) abort_run("ready stayed low for 8 cycles");
            else begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic write_word(input ecc_mem_pkg::ecc_addr_t a,
                              input ecc_mem_pkg::ecc_data_t d,
                              input ecc_mem_pkg::ecc_data_t inj);
        wait_ready();
        req_write = 1'b1;
        req_addr  = a;
        req_wdata = d;
        inj_mask  = inj;
        @(negedge clk);
        req_write = 1'b0;
        inj_mask  = '0;
        model_data[a] = d;
        model_inj[a]  = inj;
    endtask

    // poke drives a junk read, then a junk write, while ready is low.
    task automatic read_check(input ecc_mem_pkg::ecc_addr_t a, input bit poke);
        ecc_mem_pkg::ecc_data_t   exp_data;
        ecc_mem_pkg::ecc_status_e exp_status;
        int                       lat;
        int                       extra;
        int                       w;
        wait_ready();
        req_read = 1'b1;
        req_addr = a;
        @(posedge clk);
        @(negedge clk);
        req_read = 1'b0;
        check_flag("ready after read request", ready, 1'b0);
        lat = 0;
        while (!rsp_valid) begin
            if (lat == 8) abort_run("no rsp_valid within 8 cycles of a read");
            else begin
                req_read  = poke && !ready && (lat == 0);
                req_write = poke && !ready && (lat != 0);
                req_addr  = a ^ 6'd1;
                req_wdata = ~model_data[a ^ 6'd1];
                @(negedge clk);
                lat++;
            end
        end
        req_write = 1'b0;
        req_read  = 1'b0;
        // status follows from the weight of the injected mask.
        w          = $countones(model_inj[a]);
        exp_data   = model_data[a];
        exp_status = ecc_mem_pkg::ECC_OK;
        if (bypass) begin
            exp_data = model_data[a] ^ model_inj[a];
        end else if (w == 1) begin
            exp_status = ecc_mem_pkg::ECC_SBE;
            if (exp_sbe != 8'hff) exp_sbe = exp_sbe + 8'd1;
        end else if (w >= 2) begin
            exp_status = ecc_mem_pkg::ECC_DBE;
            if (exp_dbe != 8'hff) exp_dbe = exp_dbe + 8'd1;
        end
        check_count("read latency", 8'(lat), 8'd2);
        check_status("rsp_status", rsp_status, exp_status);
        if (exp_status != ecc_mem_pkg::ECC_DBE) check_data("rsp_data", rsp_data, exp_data);
        check_count("sbe_count", sbe_count, exp_sbe);
        check_count("dbe_count", dbe_count, exp_dbe);
        extra = 0;
        while (!ready) begin
            if (extra == 4) abort_run("ready did not return after a read");
            else begin
                @(negedge clk);
                extra++;
            end
        end
        if (exp_status == ecc_mem_pkg::ECC_SBE && scrub_en) begin
            check_count("busy cycles after scrubbed read", 8'(extra), 8'd1);
            model_inj[a] = '0;  // word rewritten clean.
        end else begin
            check_count("busy cycles after read", 8'(extra), 8'd0);
        end
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic clean_sweep();
        ecc_mem_pkg::ecc_data_t d;
        check_flag("ready after reset", ready, 1'b1);
        check_flag("rsp_valid after reset", rsp_valid, 1'b0);
        check_count("sbe_count after reset", sbe_count, 8'd0);
        check_count("dbe_count after reset", dbe_count, 8'd0);
        for (int i = 0; i < `ECC_MEM_DEPTH; i++) begin
            next_data(d);
            write_word(ecc_mem_pkg::ecc_addr_t'(i), d, '0);
        end
        for (int i = 0; i < `ECC_MEM_DEPTH; i++) read_check(ecc_mem_pkg::ecc_addr_t'(i), 1'b0);
    endtask

    task automatic single_bit_sweep();
        ecc_mem_pkg::ecc_data_t d;
        ecc_mem_pkg::ecc_data_t inj;
        for (int p = 0; p < `ECC_DATA_W; p++) begin
            next_data(d);
            inj    = '0;
            inj[p] = 1'b1;
            write_word(ecc_mem_pkg::ecc_addr_t'(p), d, inj);
            read_check(ecc_mem_pkg::ecc_addr_t'(p), 1'b0);
        end
    endtask

    task automatic double_bit_errors();
        ecc_mem_pkg::ecc_data_t d;
        ecc_mem_pkg::ecc_data_t inj;
        int                     p;
        for (int k = 0; k < 8; k++) begin
            next_data(d);
            p      = rng % `ECC_DATA_W;
            inj    = '0;
            inj[p] = 1'b1;
            inj[(p + 1 + k) % `ECC_DATA_W] = 1'b1;  // always a second bit.
            write_word(ecc_mem_pkg::ecc_addr_t'(32 + k), d, inj);
            read_check(ecc_mem_pkg::ecc_addr_t'(32 + k), 1'b0);
        end
    endtask

    task automatic scrub_write_back();
        ecc_mem_pkg::ecc_data_t d;
        ecc_mem_pkg::ecc_data_t inj;
        next_data(d);
        inj                         = '0;
        inj[rng[12:8] % `ECC_DATA_W] = 1'b1;
        scrub_en = 1'b1;
        write_word(6'd40, d, inj);
        read_check(6'd40, 1'b0);
        read_check(6'd40, 1'b0);
        scrub_en = 1'b0;
    endtask

    task automatic bypass_raw_read();
        ecc_mem_pkg::ecc_data_t d;
        next_data(d);
        write_word(6'd50, d, 29'h0000400);
        next_data(d);
        write_word(6'd51, d, 29'h0100011);
        bypass = 1'b1;
        read_check(6'd50, 1'b0);
        read_check(6'd51, 1'b0);
        bypass = 1'b0;
    endtask

    task automatic ignored_requests();
        ecc_mem_pkg::ecc_data_t d;
        next_data(d);
        write_word(6'd60, d, '0);
        next_data(d);
        write_word(6'd61, d, '0);
        read_check(6'd60, 1'b1);
        repeat (4) begin
            @(negedge clk);
            check_flag("rsp_valid with no request", rsp_valid, 1'b0);
        end
        read_check(6'd61, 1'b0);
        read_check(6'd60, 1'b0);
    endtask

    initial begin
        arst_n    = 1'b0;
        req_write = 1'b0;
        req_read  = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        inj_mask  = '0;
        scrub_en  = 1'b0;
        bypass    = 1'b0;
        exp_sbe   = 8'd0;
        exp_dbe   = 8'd0;
        rng       = 32'h6a793647;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        clean_sweep();
        single_bit_sweep();
        double_bit_errors();
        scrub_write_back();
        bypass_raw_read();
        ignored_requests();
        $display("TEST PASSED");
        $finish;
    end

    // watchdog.
    initial begin
        #(WATCHDOG);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== hdl/ecc_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         req_write,
    input  wire                         req_read,
    input  wire ecc_mem_pkg::ecc_addr_t req_addr,
    input  wire ecc_mem_pkg::ecc_data_t req_wdata,
    input  wire ecc_mem_pkg::ecc_data_t inj_mask,
    input  wire                         scrub_en,
    input  wire                         bypass,
    output logic                        ready,
    output logic                        rsp_valid,
    output ecc_mem_pkg::ecc_data_t      rsp_data,
    output ecc_mem_pkg::ecc_status_e    rsp_status,
    output logic [7:0]                  sbe_count,
    output logic [7:0]                  dbe_count
);

    ecc_mem_pkg::ecc_data_t corr_data;
    logic                   sbit_err;
    logic                   dbit_err;

    ecc_mem_if bus ();

    ecc_mem_ctrl ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_write  (req_write),
        .req_read   (req_read),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .inj_mask   (inj_mask),
        .scrub_en   (scrub_en),
        .ready      (ready),
        .rsp_valid  (rsp_valid),
        .rsp_data   (rsp_data),
        .rsp_status (rsp_status),
        .sbe_count  (sbe_count),
        .dbe_count  (dbe_count),
        .corr_data  (corr_data),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .mem        (bus.ctrl)
    );

    ecc_mem_array array (
        .clk  (clk),
        .port (bus.array)
    );

    // decodes the registered array output directly.
    ecc_29_codec codec (
        .data_in   (bus.rdata),
        .parity_in (bus.rpar),
        .bypass    (bypass),
        .data_out  (corr_data),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

endmodule

`default_nettype wire

// ==== hdl/ecc_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_ctrl (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         req_write,
    input  wire                         req_read,
    input  wire ecc_mem_pkg::ecc_addr_t req_addr,
    input  wire ecc_mem_pkg::ecc_data_t req_wdata,
    input  wire ecc_mem_pkg::ecc_data_t inj_mask,
    input  wire                         scrub_en,
    output logic                        ready,
    output logic                        rsp_valid,
    output ecc_mem_pkg::ecc_data_t      rsp_data,
    output ecc_mem_pkg::ecc_status_e    rsp_status,
    output logic [7:0]                  sbe_count,
    output logic [7:0]                  dbe_count,
    input  wire ecc_mem_pkg::ecc_data_t corr_data,
    input  wire                         sbit_err,
    input  wire                         dbit_err,
    ecc_mem_if.ctrl                     mem
);

    ecc_mem_pkg::ctrl_state_e state;
    ecc_mem_pkg::ctrl_state_e state_nxt;
    ecc_mem_pkg::ecc_addr_t   addr_q;
    ecc_mem_pkg::ecc_data_t   clean_data;
    logic                     rd_start;
    logic                     scrub_wr;
    logic                     check;

    assign ready    = (state == ecc_mem_pkg::ST_IDLE);
    assign rd_start = ready && req_read && !req_write;  // write wins a tie.
    assign scrub_wr = (state == ecc_mem_pkg::ST_SCRUB);
    assign check    = (state == ecc_mem_pkg::ST_RD_CHECK);

    // ------------------------------
    // array port
    // ------------------------------
    assign clean_data = scrub_wr ? rsp_data : req_wdata;
    assign mem.addr   = ready ? req_addr : addr_q;
    assign mem.we     = (ready && req_write) || scrub_wr;
    assign mem.re     = (state == ecc_mem_pkg::ST_RD_WAIT);
    assign mem.wdata  = scrub_wr ? rsp_data : (req_wdata ^ inj_mask);
    assign mem.wpar   = ecc_mem_pkg::ecc_encode(clean_data);  // from clean data.

    // ------------------------------
    // state machine
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ecc_mem_pkg::ST_IDLE:
                if (rd_start) state_nxt = ecc_mem_pkg::ST_RD_WAIT;
            ecc_mem_pkg::ST_RD_WAIT:
                state_nxt = ecc_mem_pkg::ST_RD_CHECK;
            ecc_mem_pkg::ST_RD_CHECK:
                state_nxt = (scrub_en && sbit_err) ? ecc_mem_pkg::ST_SCRUB
                                                   : ecc_mem_pkg::ST_IDLE;
            ecc_mem_pkg::ST_SCRUB:
                state_nxt = ecc_mem_pkg::ST_IDLE;
            default:
                state_nxt = ecc_mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ecc_mem_pkg::ST_IDLE;
            rsp_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            rsp_valid <= check;
        end
    end

    // held address and read result.
    always_ff @(posedge clk) begin
        if (rd_start) begin
            addr_q <= req_addr;
        end
        if (check) begin
            rsp_data <= corr_data;  // also the scrub payload.
            if (dbit_err) begin
                rsp_status <= ecc_mem_pkg::ECC_DBE;
            end else if (sbit_err) begin
                rsp_status <= ecc_mem_pkg::ECC_SBE;
            end else begin
                rsp_status <= ecc_mem_pkg::ECC_OK;
            end
        end
    end

    // saturating event counters.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sbe_count <= 8'd0;
            dbe_count <= 8'd0;
        end else if (check) begin
            if (sbit_err && sbe_count != 8'hff) sbe_count <= sbe_count + 8'd1;
            if (dbit_err && dbe_count != 8'hff) dbe_count <= dbe_count + 8'd1;
        end
    end

    a_rsp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held for more than one cycle");

    a_scrub_after_sbe: assert property (@(posedge clk) disable iff (!arst_n)
        scrub_wr |-> $past(check) && rsp_status == ecc_mem_pkg::ECC_SBE)
        else $error("scrub entered without a single-bit result");

endmodule

`default_nettype wire

// ==== hdl/ecc_mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ecc_mem_cfg.svh"

module ecc_mem_array (
    input wire       clk,
    ecc_mem_if.array port
);

    logic [`ECC_DATA_W-1:0] data_mem [`ECC_MEM_DEPTH];
    logic [`ECC_PAR_W-1:0]  par_mem  [`ECC_MEM_DEPTH];

    // ------------------------------
    // write side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (port.we) begin
            data_mem[port.addr] <= port.wdata;
            par_mem[port.addr]  <= port.wpar;
        end
    end

    // ------------------------------
    // registered read
    // ------------------------------
    always_ff @(posedge clk) begin
        if (port.re) begin
            port.rdata <= data_mem[port.addr];  // held until next re.
            port.rpar  <= par_mem[port.addr];
        end
    end

    // controller must never overlap the strobes.
    a_no_rd_wr: assert property (@(posedge clk)
        !(port.we === 1'b1 && port.re === 1'b1))
        else $error("array saw we and re in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/ecc_29_codec.sv ====
`timescale 1ns/1ps
`default_nettype none

module ecc_29_codec (
    input  wire ecc_mem_pkg::ecc_data_t data_in,
    input  wire ecc_mem_pkg::ecc_par_t  parity_in,
    input  wire                         bypass,
    output ecc_mem_pkg::ecc_data_t      data_out,
    output logic                        sbit_err,
    output logic                        dbit_err
);

    ecc_mem_pkg::ecc_par_t     syndrome;
    ecc_mem_pkg::ecc_data_t    mask;
    ecc_mem_pkg::ecc_status_e  err_class;

    assign syndrome = parity_in ^ ecc_mem_pkg::ecc_encode(data_in);

    // ------------------------------
    // syndrome decode
    // ------------------------------
    always_comb begin
        mask      = '0;
        err_class = ecc_mem_pkg::ECC_SBE;
        case (syndrome)
            7'b0000000: err_class = ecc_mem_pkg::ECC_OK;
            7'b1000011: mask = 29'h0000001;
            7'b1000101: mask = 29'h0000002;
            7'b1000110: mask = 29'h0000004;
            7'b0000111: mask = 29'h0000008;
            7'b1001001: mask = 29'h0000010;
            7'b1001010: mask = 29'h0000020;
            7'b0001011: mask = 29'h0000040;
            7'b1001100: mask = 29'h0000080;
            7'b0001101: mask = 29'h0000100;
            7'b0001110: mask = 29'h0000200;
            7'b1001111: mask = 29'h0000400;
            7'b1010001: mask = 29'h0000800;
            7'b1010010: mask = 29'h0001000;
            7'b0010011: mask = 29'h0002000;
            7'b1010100: mask = 29'h0004000;
            7'b0010101: mask = 29'h0008000;
            7'b0010110: mask = 29'h0010000;
            7'b1010111: mask = 29'h0020000;
            7'b1011000: mask = 29'h0040000;
            7'b0011001: mask = 29'h0080000;
            7'b0011010: mask = 29'h0100000;
            7'b1011011: mask = 29'h0200000;
            7'b0011100: mask = 29'h0400000;
            7'b1011101: mask = 29'h0800000;
            7'b1011110: mask = 29'h1000000;
            7'b0011111: mask = 29'h2000000;
            7'b1100001: mask = 29'h4000000;
            7'b1100010: mask = 29'h8000000;
            7'b0100011: mask = 29'h10000000;
            default: begin
                // lone check bit flip leaves the data intact.
                if (!$onehot(syndrome)) begin
                    err_class = ecc_mem_pkg::ECC_DBE;
                end
            end
        endcase
    end

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && (err_class == ecc_mem_pkg::ECC_SBE);
    assign dbit_err = !bypass && (err_class == ecc_mem_pkg::ECC_DBE);

    always_comb begin
        a_flags_exclusive: assert final (!(sbit_err && dbit_err))
            else $error("codec raised single and double error together");
    end

endmodule

`default_nettype wire

// ==== hdl/ecc_mem_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "ecc_mem_cfg.svh"

// single port of the codeword array.
interface ecc_mem_if;

    logic [`ECC_ADDR_W-1:0] addr;
    logic                   we;     // one cycle strobe.
    logic [`ECC_DATA_W-1:0] wdata;
    logic [`ECC_PAR_W-1:0]  wpar;
    logic                   re;     // never with we.
    logic [`ECC_DATA_W-1:0] rdata;  // valid after the re edge.
    logic [`ECC_PAR_W-1:0]  rpar;

    modport ctrl (
        output addr, we, wdata, wpar, re,
        input  rdata, rpar
    );

    modport array (
        input  addr, we, wdata, wpar, re,
        output rdata, rpar
    );

endinterface

`default_nettype wire

// ==== hdl/ecc_mem_pkg.sv ====
`default_nettype none
`include "ecc_mem_cfg.svh"

package ecc_mem_pkg;

    typedef logic [`ECC_DATA_W-1:0] ecc_data_t;
    typedef logic [`ECC_PAR_W-1:0]  ecc_par_t;
    typedef logic [`ECC_ADDR_W-1:0] ecc_addr_t;

    typedef enum logic [1:0] {
        ECC_OK  = 2'd0,
        ECC_SBE = 2'd1,  // corrected.
        ECC_DBE = 2'd2   // uncorrectable.
    } ecc_status_e;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,
        ST_RD_WAIT  = 2'd1,
        ST_RD_CHECK = 2'd2,
        ST_SCRUB    = 2'd3
    } ctrl_state_e;

    // ------------------------------
    // check bit generation
    // ------------------------------
    // every data column has odd weight, so any two flips give an even syndrome.
    function automatic ecc_par_t ecc_encode(input ecc_data_t d);
        ecc_par_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13]
             ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13]
             ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14]
             ^ d[15] ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18]
             ^ d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[4] = d[11] ^ d[12] ^ d[13] ^ d[14] ^ d[15] ^ d[16] ^ d[17] ^ d[18]
             ^ d[19] ^ d[20] ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25];
        p[5] = d[26] ^ d[27] ^ d[28];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12]
             ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27];
        return p;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ecc_mem_cfg.svh ====
`ifndef ECC_MEM_CFG_SVH
`define ECC_MEM_CFG_SVH

// ------------------------------
// word geometry
// ------------------------------
`define ECC_DATA_W      29  // payload bits.
`define ECC_PAR_W       7   // hsiao check bits.

// array size
`define ECC_MEM_DEPTH   64
`define ECC_ADDR_W      6   // log2 of depth.

`endif
